// ==== rtl/block_err_pkg.sv ====
package block_err_pkg;

        // coded block geometry
        localparam int NB_BLOCK   = 66;
        localparam int NB_SH      = 2;
        localparam int NB_PAYLOAD = NB_BLOCK - NB_SH;   // also the mask width

        // 64b/66b sync headers
        localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;
        localparam logic [NB_SH-1:0] SH_DATA = 2'b01;

        // one-hot corruption modes, anything else disables injection
        localparam int NB_MODE = 4;
        localparam logic [NB_MODE-1:0] MODE_ALIGN = 4'b0001;   // aligner tagged blocks
        localparam logic [NB_MODE-1:0] MODE_CTRL  = 4'b0010;   // control blocks
        localparam logic [NB_MODE-1:0] MODE_DATA  = 4'b0100;   // data blocks
        localparam logic [NB_MODE-1:0] MODE_ALL   = 4'b1000;   // every block

        // countdown widths
        localparam int NB_BURST  = 10;
        localparam int NB_PERIOD = 10;
        localparam int NB_REPEAT = 4;

        // monitor statistics
        localparam int NB_STAT = 32;

        // header over payload
        typedef struct packed {
                logic [NB_SH-1:0]      sh;
                logic [NB_PAYLOAD-1:0] payload;
        } coded_block_s;

        // same 66 bits, raw or split
        typedef union packed {
                logic [NB_BLOCK-1:0] raw;
                coded_block_s        fld;
        } coded_block_u;

endpackage

// ==== rtl/err_cfg_if.sv ====
interface err_cfg_if;

        logic [block_err_pkg::NB_MODE-1:0]    mode;     // one-hot mode
        logic [block_err_pkg::NB_PAYLOAD-1:0] mask;     // payload bits to flip
        logic [block_err_pkg::NB_BURST-1:0]   burst;    // corrupted blocks per period
        logic [block_err_pkg::NB_PERIOD-1:0]  period;   // valid blocks per period
        logic [block_err_pkg::NB_REPEAT-1:0]  repeats;  // extra periods, repeat is a keyword
        logic                                 apply;    // one cycle, new values live

        // register block side
        modport cfg_src (
                output mode, mask, burst, period, repeats, apply
        );

        // countdowns
        modport sched_dst (
                input burst, period, repeats, apply
        );

        // block classification and flip
        modport brk_dst (
                input mode, mask
        );

        // bit statistics
        modport mon_dst (
                input mask
        );

endinterface

// ==== rtl/err_cfg_regs.sv ====
module err_cfg_regs (
        input  logic                                 i_clock,
        input  logic                                 i_reset,
        input  logic                                 i_cfg_req,
        input  logic [block_err_pkg::NB_MODE-1:0]    i_cfg_mode,
        input  logic [block_err_pkg::NB_PAYLOAD-1:0] i_cfg_mask,
        input  logic [block_err_pkg::NB_BURST-1:0]   i_cfg_burst,
        input  logic [block_err_pkg::NB_PERIOD-1:0]  i_cfg_period,
        input  logic [block_err_pkg::NB_REPEAT-1:0]  i_cfg_repeat,
        output logic                                 o_cfg_ack,
        err_cfg_if.cfg_src                           cfg
);

        logic capture;  // req seen, no ack yet, not already applying

        assign capture = i_cfg_req && !o_cfg_ack && !cfg.apply;

        // applied mode and mask, zero means nothing is touched
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        cfg.mode <= '0;
                        cfg.mask <= '0;
                end
                else if (capture)
                begin
                        cfg.mode <= i_cfg_mode;
                        cfg.mask <= i_cfg_mask;
                end
        end

        // countdown reload values
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        cfg.burst   <= '0;
                        cfg.period  <= '0;
                        cfg.repeats <= '0;
                end
                else if (capture)
                begin
                        cfg.burst   <= i_cfg_burst;
                        cfg.period  <= i_cfg_period;
                        cfg.repeats <= i_cfg_repeat;
                end
        end

        // apply lines up with the first cycle of the new values
        // ack follows one edge later, drops once req is seen low
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        cfg.apply <= 1'b0;
                        o_cfg_ack <= 1'b0;
                end
                else
                begin
                        cfg.apply <= capture;
                        if (cfg.apply)
                                o_cfg_ack <= 1'b1;
                        else if (!i_cfg_req)
                                o_cfg_ack <= 1'b0;      // phase 4
                end
        end

        // ack only ever answers a request that started the capture
        a_ack_needs_req: assert property (@(posedge i_clock) disable iff (i_reset)
                $rose(o_cfg_ack) |-> $past(i_cfg_req, 2));

        a_apply_single: assert property (@(posedge i_clock) disable iff (i_reset)
                cfg.apply |=> !cfg.apply);

endmodule

// ==== rtl/err_scheduler.sv ====
module err_scheduler (
        input  logic       i_clock,
        input  logic       i_reset,
        input  logic       i_valid,
        input  logic       i_eligible,     // block matches the mode
        output logic       o_hit,          // corrupt this block
        err_cfg_if.sched_dst cfg
);

        logic [block_err_pkg::NB_BURST-1:0]  burst_cnt;   // hits left this period
        logic [block_err_pkg::NB_PERIOD-1:0] period_cnt;  // valid blocks left this period
        logic [block_err_pkg::NB_REPEAT-1:0] repeat_cnt;  // periods left after this one

        logic burst_on;
        logic period_on;
        logic repeat_on;
        logic period_end;

        assign burst_on   = (burst_cnt != '0);
        assign period_on  = (period_cnt != '0);
        assign repeat_on  = (repeat_cnt != '0);
        assign period_end = (period_cnt == block_err_pkg::NB_PERIOD'(1));

        // burst window sits at the start of each period
        // nothing is hit while a new config is being loaded
        assign o_hit = i_valid && i_eligible && burst_on && period_on && !cfg.apply;

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        burst_cnt  <= '0;
                        period_cnt <= '0;
                        repeat_cnt <= '0;
                end
                else if (cfg.apply)     // wins over any block this cycle
                begin
                        burst_cnt  <= cfg.burst;
                        period_cnt <= cfg.period;
                        repeat_cnt <= cfg.repeats;
                end
                else if (i_valid)
                begin
                        if (period_end)
                        begin
                                if (repeat_on)  // next period with the same pattern
                                begin
                                        burst_cnt  <= cfg.burst;
                                        period_cnt <= cfg.period;
                                        repeat_cnt <= repeat_cnt - 1'b1;
                                end
                                else            // last period done so injection stops
                                begin
                                        burst_cnt  <= '0;
                                        period_cnt <= '0;
                                end
                        end
                        else
                        begin
                                if (period_on)
                                        period_cnt <= period_cnt - 1'b1;
                                if (o_hit)
                                        burst_cnt <= burst_cnt - 1'b1;
                        end
                end
                // invalid cycles hold everything
        end

        // a spent burst stays spent until the next reload
        a_burst_no_wrap: assert property (@(posedge i_clock) disable iff (i_reset)
                (!burst_on && !cfg.apply && !(i_valid && period_end)) |=> !burst_on);

endmodule

// ==== rtl/payload_breaker.sv ====
module payload_breaker (
        input  logic                               i_clock,
        input  logic                               i_reset,
        input  logic                               i_valid,
        input  logic                               i_aligner_tag,  // block is an aligner
        input  logic [block_err_pkg::NB_BLOCK-1:0] i_data,
        input  logic                               i_hit,          // from the scheduler
        output logic                               o_eligible,     // to the scheduler
        output logic                               o_valid,
        output logic                               o_aligner_tag,
        output logic [block_err_pkg::NB_BLOCK-1:0] o_data,
        output logic                               o_hit,          // registered, to monitor
        err_cfg_if.brk_dst                         cfg
);

        block_err_pkg::coded_block_u blk_in;
        block_err_pkg::coded_block_u blk_err;

        logic sh_ctrl;
        logic sh_data;

        assign blk_in.raw = i_data;

        // classify by sync header
        assign sh_ctrl = (blk_in.fld.sh == block_err_pkg::SH_CTRL);
        assign sh_data = (blk_in.fld.sh == block_err_pkg::SH_DATA);

        // invalid headers only match in MODE_ALL or MODE_ALIGN
        assign o_eligible = (cfg.mode == block_err_pkg::MODE_ALL) ||
                            ((cfg.mode == block_err_pkg::MODE_ALIGN) && i_aligner_tag) ||
                            ((cfg.mode == block_err_pkg::MODE_CTRL) && sh_ctrl) ||
                            ((cfg.mode == block_err_pkg::MODE_DATA) && sh_data);

        // flip under mask, header kept
        assign blk_err.fld.sh      = blk_in.fld.sh;
        assign blk_err.fld.payload = blk_in.fld.payload ^ cfg.mask;

        // control outputs
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_valid <= 1'b0;
                        o_hit   <= 1'b0;
                end
                else
                begin
                        o_valid <= i_valid;
                        o_hit   <= i_hit;
                end
        end

        // block and tag, loaded every cycle
        always_ff @(posedge i_clock)
        begin
                o_aligner_tag <= i_aligner_tag;
                if (i_hit)
                        o_data <= blk_err.raw;
                else
                        o_data <= i_data;       // passthrough
        end

        // sync header survives the stage untouched
        a_sh_kept: assert property (@(posedge i_clock) disable iff (i_reset)
                !$past(i_reset) |->
                        (o_data[block_err_pkg::NB_BLOCK-1 -: block_err_pkg::NB_SH] ==
                         $past(i_data[block_err_pkg::NB_BLOCK-1 -: block_err_pkg::NB_SH])));

endmodule

// ==== rtl/err_monitor.sv ====
module err_monitor (
        input  logic                              i_clock,
        input  logic                              i_reset,
        input  logic                              i_hit,         // block left corrupted
        output logic [block_err_pkg::NB_STAT-1:0] o_err_blocks,
        output logic [block_err_pkg::NB_STAT-1:0] o_err_bits,
        err_cfg_if.mon_dst                        cfg
);

        logic [block_err_pkg::NB_PAYLOAD-1:0]       mask_q;      // mask of the hit cycle
        logic [$clog2(block_err_pkg::NB_PAYLOAD+1)-1:0] mask_ones;
        logic [block_err_pkg::NB_STAT:0]            bits_sum;    // one carry bit

        // hit is one cycle late, so is the mask it used
        always_ff @(posedge i_clock)
        begin
                mask_q <= cfg.mask;
        end

        assign mask_ones = $bits(mask_ones)'($countones(mask_q));
        assign bits_sum  = {1'b0, o_err_bits} + (block_err_pkg::NB_STAT+1)'(mask_ones);

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_err_blocks <= '0;
                        o_err_bits   <= '0;
                end
                else if (i_hit)
                begin
                        if (o_err_blocks != '1)
                                o_err_blocks <= o_err_blocks + 1'b1;
                        // clamp on overflow
                        if (bits_sum[block_err_pkg::NB_STAT])
                                o_err_bits <= '1;
                        else
                                o_err_bits <= bits_sum[block_err_pkg::NB_STAT-1:0];
                end
        end

endmodule

// ==== rtl/block_err_inject_top.sv ====
module block_err_inject_top (
        input  logic                                 i_clock,
        input  logic                                 i_reset,
        // block stream in
        input  logic                                 i_valid,
        input  logic                                 i_aligner_tag,
        input  logic [block_err_pkg::NB_BLOCK-1:0]   i_data,
        // config handshake
        input  logic                                 i_cfg_req,
        input  logic [block_err_pkg::NB_MODE-1:0]    i_cfg_mode,
        input  logic [block_err_pkg::NB_PAYLOAD-1:0] i_cfg_mask,
        input  logic [block_err_pkg::NB_BURST-1:0]   i_cfg_burst,
        input  logic [block_err_pkg::NB_PERIOD-1:0]  i_cfg_period,
        input  logic [block_err_pkg::NB_REPEAT-1:0]  i_cfg_repeat,
        output logic                                 o_cfg_ack,
        // block stream out, one cycle later
        output logic                                 o_valid,
        output logic                                 o_aligner_tag,
        output logic [block_err_pkg::NB_BLOCK-1:0]   o_data,
        // error statistics
        output logic [block_err_pkg::NB_STAT-1:0]    o_err_blocks,
        output logic [block_err_pkg::NB_STAT-1:0]    o_err_bits
);

        logic eligible;         // breaker to scheduler
        logic hit;              // scheduler to breaker
        logic out_hit;          // breaker to monitor, registered

        err_cfg_if u_cfg ();

        err_cfg_regs u_cfg_regs (
                .i_clock      (i_clock),
                .i_reset      (i_reset),
                .i_cfg_req    (i_cfg_req),
                .i_cfg_mode   (i_cfg_mode),
                .i_cfg_mask   (i_cfg_mask),
                .i_cfg_burst  (i_cfg_burst),
                .i_cfg_period (i_cfg_period),
                .i_cfg_repeat (i_cfg_repeat),
                .o_cfg_ack    (o_cfg_ack),
                .cfg          (u_cfg.cfg_src)
        );

        err_scheduler u_scheduler (
                .i_clock    (i_clock),
                .i_reset    (i_reset),
                .i_valid    (i_valid),
                .i_eligible (eligible),
                .o_hit      (hit),
                .cfg        (u_cfg.sched_dst)
        );

        payload_breaker u_breaker (
                .i_clock       (i_clock),
                .i_reset       (i_reset),
                .i_valid       (i_valid),
                .i_aligner_tag (i_aligner_tag),
                .i_data        (i_data),
                .i_hit         (hit),
                .o_eligible    (eligible),
                .o_valid       (o_valid),
                .o_aligner_tag (o_aligner_tag),
                .o_data        (o_data),
                .o_hit         (out_hit),
                .cfg           (u_cfg.brk_dst)
        );

        err_monitor u_monitor (
                .i_clock      (i_clock),
                .i_reset      (i_reset),
                .i_hit        (out_hit),
                .o_err_blocks (o_err_blocks),
                .o_err_bits   (o_err_bits),
                .cfg          (u_cfg.mon_dst)
        );

endmodule

// ==== verif/tb_block_err_inject.sv ====
module tb_block_err_inject;

        localparam int CLK_PERIOD       = 10;
        localparam int N_RESET          = 8;
        localparam int N_PLAIN          = 40;   // no config written yet
        localparam int N_MODE_RUNS      = 7;    // four modes plus three bad codes
        localparam int N_MODE_BLOCKS    = 80;
        localparam int N_PATTERNS       = 12;   // burst, period, repeat sweeps
        localparam int N_PATTERN_BLOCKS = 100;
        localparam int N_RECFG          = 6;    // mid burst reloads
        localparam int N_RECFG_BLOCKS   = 12;
        localparam int HS_LIMIT         = 8;    // cycles allowed per handshake phase
        localparam int N_CONFIGS        = N_MODE_RUNS + N_PATTERNS + N_RECFG + 1;
        localparam int TOTAL_CYCLES     = N_RESET + N_PLAIN + N_MODE_RUNS * N_MODE_BLOCKS +
                                          N_PATTERNS * N_PATTERN_BLOCKS +
                                          (N_RECFG + 1) * N_RECFG_BLOCKS +
                                          N_CONFIGS * 2 * HS_LIMIT;
        localparam int MARGIN_CYCLES    = 200;

        logic                                 i_clock;
        logic                                 i_reset;
        logic                                 i_valid;
        logic                                 i_aligner_tag;
        logic [block_err_pkg::NB_BLOCK-1:0]   i_data;
        logic                                 i_cfg_req;
        logic [block_err_pkg::NB_MODE-1:0]    i_cfg_mode;
        logic [block_err_pkg::NB_PAYLOAD-1:0] i_cfg_mask;
        logic [block_err_pkg::NB_BURST-1:0]   i_cfg_burst;
        logic [block_err_pkg::NB_PERIOD-1:0]  i_cfg_period;
        logic [block_err_pkg::NB_REPEAT-1:0]  i_cfg_repeat;
        logic                                 o_cfg_ack;
        logic                                 o_valid;
        logic                                 o_aligner_tag;
        logic [block_err_pkg::NB_BLOCK-1:0]   o_data;
        logic [block_err_pkg::NB_STAT-1:0]    o_err_blocks;
        logic [block_err_pkg::NB_STAT-1:0]    o_err_bits;

        // values for the next rising edge
        logic                                 nxt_reset;
        logic                                 nxt_valid;
        logic                                 nxt_tag;
        logic [block_err_pkg::NB_BLOCK-1:0]   nxt_data;
        logic                                 nxt_req;
        logic [block_err_pkg::NB_MODE-1:0]    nxt_mode;
        logic [block_err_pkg::NB_PAYLOAD-1:0] nxt_mask;
        logic [block_err_pkg::NB_BURST-1:0]   nxt_burst;
        logic [block_err_pkg::NB_PERIOD-1:0]  nxt_period;
        logic [block_err_pkg::NB_REPEAT-1:0]  nxt_repeat;

        // reference model state
        logic                                 m_ack;
        logic                                 m_apply;
        logic [block_err_pkg::NB_MODE-1:0]    m_mode;
        logic [block_err_pkg::NB_PAYLOAD-1:0] m_mask;
        logic [block_err_pkg::NB_BURST-1:0]   m_burst;
        logic [block_err_pkg::NB_PERIOD-1:0]  m_period;
        logic [block_err_pkg::NB_REPEAT-1:0]  m_repeat;
        logic [block_err_pkg::NB_BURST-1:0]   m_burst_cnt;
        logic [block_err_pkg::NB_PERIOD-1:0]  m_period_cnt;
        logic [block_err_pkg::NB_REPEAT-1:0]  m_repeat_cnt;
        logic                                 exp_valid;
        logic                                 exp_tag;
        logic [block_err_pkg::NB_BLOCK-1:0]   exp_data;
        logic                                 pend_hit;     // hit waiting for the monitor
        logic [6:0]                           pend_bits;    // its mask popcount
        logic [block_err_pkg::NB_STAT-1:0]    m_blocks;
        logic [block_err_pkg::NB_STAT-1:0]    m_bits;

        logic [31:0] lfsr_state;
        logic        gaps_on;       // random idle cycles between blocks
        int          errors;
        int          checks;
        int          n_hits;

        block_err_inject_top uut (
                .i_clock       (i_clock),
                .i_reset       (i_reset),
                .i_valid       (i_valid),
                .i_aligner_tag (i_aligner_tag),
                .i_data        (i_data),
                .i_cfg_req     (i_cfg_req),
                .i_cfg_mode    (i_cfg_mode),
                .i_cfg_mask    (i_cfg_mask),
                .i_cfg_burst   (i_cfg_burst),
                .i_cfg_period  (i_cfg_period),
                .i_cfg_repeat  (i_cfg_repeat),
                .o_cfg_ack     (o_cfg_ack),
                .o_valid       (o_valid),
                .o_aligner_tag (o_aligner_tag),
                .o_data        (o_data),
                .o_err_blocks  (o_err_blocks),
                .o_err_bits    (o_err_bits)
        );

        initial
        begin
                i_clock = 1'b0;
                forever
                        #(CLK_PERIOD / 2) i_clock = ~i_clock;
        end

        // fibonacci lfsr, taps 32 22 2 1, one step per bit
        function automatic logic [63:0] take_bits(input int n);
                logic [63:0] bits;
                logic        fb;
                bits = '0;
                for (int k = 0; k < n; k++)
                begin
                        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
                        lfsr_state = {lfsr_state[30:0], fb};
                        bits = {bits[62:0], fb};
                end
                return bits;
        endfunction

        function automatic logic [6:0] ones_in(input logic [63:0] mask);
                logic [6:0] cnt;
                cnt = '0;
                for (int k = 0; k < 64; k++)
                        cnt = cnt + 7'(mask[k]);
                return cnt;
        endfunction

        function automatic logic [3:0] mode_for(input int idx);
                case (idx)
                        0:       return block_err_pkg::MODE_ALIGN;
                        1:       return block_err_pkg::MODE_CTRL;
                        2:       return block_err_pkg::MODE_DATA;
                        3:       return block_err_pkg::MODE_ALL;
                        4:       return 4'b0000;        // disabled
                        5:       return 4'b0110;        // two bits set
                        default: return 4'b1111;
                endcase
        endfunction

        task automatic compare_value(input logic [65:0] actual, input logic [65:0] expected,
                                     input string what);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("FAIL %0t: %s expected %h got %h", $time, what, expected, actual);
                end
        endtask

        // one clock edge of the model, from the inputs the DUT samples now
        task automatic predict_edge();
                logic                            elig;
                logic                            hit;
                logic                            capture;
                logic [block_err_pkg::NB_STAT:0] sum;
                if (i_reset)
                begin
                        m_ack = 1'b0;
                        m_apply = 1'b0;
                        {m_mode, m_mask, m_burst, m_period, m_repeat} = '0;
                        {m_burst_cnt, m_period_cnt, m_repeat_cnt} = '0;
                        {exp_valid, pend_hit, m_blocks, m_bits} = '0;
                        return;
                end
                if (pend_hit)   // monitor is one edge behind the block
                begin
                        if (m_blocks != '1)
                                m_blocks++;
                        sum = {1'b0, m_bits} + 33'(pend_bits);
                        m_bits = sum[32] ? '1 : sum[31:0];
                end
                elig = (m_mode == block_err_pkg::MODE_ALL) ||
                       (m_mode == block_err_pkg::MODE_ALIGN && i_aligner_tag) ||
                       (m_mode == block_err_pkg::MODE_CTRL && i_data[65:64] == 2'b10) ||
                       (m_mode == block_err_pkg::MODE_DATA && i_data[65:64] == 2'b01);
                hit = i_valid && elig && m_burst_cnt != '0 && m_period_cnt != '0 && !m_apply;
                if (hit)
                        n_hits++;
                exp_valid = i_valid;
                exp_tag   = i_aligner_tag;
                exp_data  = hit ? {i_data[65:64], i_data[63:0] ^ m_mask} : i_data;
                pend_hit  = hit;
                pend_bits = ones_in(m_mask);
                if (m_apply)    // reload beats any block this cycle
                        {m_burst_cnt, m_period_cnt, m_repeat_cnt} = {m_burst, m_period, m_repeat};
                else if (i_valid && m_period_cnt == 10'd1)
                begin
                        if (m_repeat_cnt != '0)
                        begin
                                {m_burst_cnt, m_period_cnt} = {m_burst, m_period};
                                m_repeat_cnt--;
                        end
                        else
                                {m_burst_cnt, m_period_cnt} = '0;      // last period over
                end
                else if (i_valid)
                begin
                        if (m_period_cnt != '0)
                                m_period_cnt--;
                        if (hit)
                                m_burst_cnt--;
                end
                capture = i_cfg_req && !m_ack && !m_apply;
                if (m_apply)
                        m_ack = 1'b1;
                else if (!i_cfg_req)
                        m_ack = 1'b0;
                m_apply = capture;      // new values and apply share a cycle
                if (capture)
                        {m_mode, m_mask} = {i_cfg_mode, i_cfg_mask};
                if (capture)
                        {m_burst, m_period, m_repeat} = {i_cfg_burst, i_cfg_period, i_cfg_repeat};
        endtask

        // drive on the rising edge, check at the falling edge
        task automatic tick();
                @(posedge i_clock);
                predict_edge();
                i_reset       <= nxt_reset;
                i_valid       <= nxt_valid;
                i_aligner_tag <= nxt_tag;
                i_data        <= nxt_data;
                i_cfg_req     <= nxt_req;
                i_cfg_mode    <= nxt_mode;
                i_cfg_mask    <= nxt_mask;
                i_cfg_burst   <= nxt_burst;
                i_cfg_period  <= nxt_period;
                i_cfg_repeat  <= nxt_repeat;
                @(negedge i_clock);
                compare_value(66'(o_valid), 66'(exp_valid), "o_valid");
                if (exp_valid)
                begin
                        compare_value(66'(o_aligner_tag), 66'(exp_tag), "o_aligner_tag");
                        compare_value(o_data, exp_data, "o_data");
                end
                compare_value(66'(o_cfg_ack), 66'(m_ack), "o_cfg_ack");
                compare_value(66'(o_err_blocks), 66'(m_blocks), "o_err_blocks");
                compare_value(66'(o_err_bits), 66'(m_bits), "o_err_bits");
        endtask

        task automatic random_block();
                logic [1:0]  hdr;
                logic [63:0] pay;
                nxt_valid = !(gaps_on && take_bits(2) == 64'd0);
                nxt_tag   = (take_bits(2) == 64'd3);   // roughly one in four
                hdr       = 2'(take_bits(2));           // includes 00 and 11
                pay       = take_bits(64);
                nxt_data  = {hdr, pay};
        endtask

        task automatic run_blocks(input int n);
                repeat (n)
                begin
                        random_block();
                        tick();
                end
        endtask

        // four phase write, stream keeps running underneath
        task automatic configure(input logic [3:0] mode, input logic [63:0] mask,
                                 input logic [9:0] burst, input logic [9:0] period,
                                 input logic [3:0] repeats);
                int waited;
                {nxt_mode, nxt_mask} = {mode, mask};
                {nxt_burst, nxt_period, nxt_repeat} = {burst, period, repeats};
                nxt_req = 1'b1;
                waited = 0;
                while (!o_cfg_ack && waited < HS_LIMIT)
                begin
                        run_blocks(1);
                        waited++;
                end
                if (!o_cfg_ack)
                begin
                        errors++;
                        $display("handshake error at %0t: ack never rose after req", $time);
                end
                nxt_req  = 1'b0;
                nxt_mode = 4'(take_bits(4));    // junk while req is low, must not load
                nxt_mask = take_bits(64);
                waited = 0;
                while (o_cfg_ack && waited < HS_LIMIT)
                begin
                        run_blocks(1);
                        waited++;
                end
                if (o_cfg_ack)
                begin
                        errors++;
                        $display("handshake error at %0t: ack stayed high after req fell", $time);
                end
        endtask

        initial
        begin
                logic [63:0] mask;
                logic [9:0]  burst;
                logic [9:0]  period;
                lfsr_state = 32'hd25f6e69;
                {errors, checks, n_hits} = '0;
                {i_reset, i_valid, i_aligner_tag, i_data, i_cfg_req} <= {1'b1, 69'd0};
                {i_cfg_mode, i_cfg_mask, i_cfg_burst, i_cfg_period, i_cfg_repeat} <= '0;
                {nxt_valid, nxt_tag, nxt_data, nxt_req} = '0;
                {nxt_mode, nxt_mask, nxt_burst, nxt_period, nxt_repeat} = '0;
                gaps_on = 1'b1;
                for (int k = 1; k <= N_RESET; k++)
                begin
                        nxt_reset = (k < N_RESET);
                        tick();
                end
                run_blocks(N_PLAIN);    // plain one cycle passthrough
                for (int r = 0; r < N_MODE_RUNS; r++)
                begin
                        burst  = 10'(8 + take_bits(4));
                        period = burst + 10'(8 + take_bits(4));
                        configure(mode_for(r), take_bits(64), burst, period, 4'(take_bits(2)));
                        run_blocks(N_MODE_BLOCKS);
                end
                for (int p = 0; p < N_PATTERNS; p++)
                begin
                        mask = take_bits(64);
                        mask = mask & take_bits(64);    // sparser flips
                        configure(4'(4'b0001 << take_bits(2)), mask, 10'(take_bits(3)),
                                  10'(take_bits(4)), 4'(take_bits(2)));
                        run_blocks(N_PATTERN_BLOCKS);   // runs past the last repeat
                end
                gaps_on = 1'b0;         // back to back, reloads land inside bursts
                for (int c = 0; c <= N_RECFG; c++)
                begin
                        burst = 10'(30 + take_bits(4));
                        configure(block_err_pkg::MODE_ALL, take_bits(64), burst,
                                  burst + 10'd20, 4'(take_bits(1)));
                        run_blocks(N_RECFG_BLOCKS);
                end
                nxt_valid = 1'b0;
                repeat (3)
                        tick();         // let the monitor settle
                if (n_hits == 0)
                begin
                        errors++;
                        $display("no block was corrupted during the whole run");
                end
                $display("checks %0d, errors %0d, corrupted blocks %0d", checks, errors, n_hits);
                if (errors == 0)
                        $display("TESTS PASSED");
                else
                        $display("TESTS FAILED");
                $finish;
        end

        initial
        begin
                #(CLK_PERIOD * (TOTAL_CYCLES + MARGIN_CYCLES));
                $display("watchdog timed out, run still going after %0d cycles",
                         TOTAL_CYCLES + MARGIN_CYCLES);
                $display("TESTS FAILED");
                $finish;
        end

endmodule

// ==== block_err_inject.f ====
rtl/block_err_pkg.sv
rtl/err_cfg_if.sv
rtl/err_cfg_regs.sv
rtl/err_scheduler.sv
rtl/payload_breaker.sv
rtl/err_monitor.sv
rtl/block_err_inject_top.sv
verif/tb_block_err_inject.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= block_err_inject.f
TB_TOP    ?= tb_block_err_inject
RTL_TOP   ?= block_err_inject_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
